// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    localparam int addr_w = 32;
    localparam int word_w = 32;

    // slave response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // master to slave with one address phase per transaction
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;   // beats minus one
        logic [word_w-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              req_ready;  // address accepted
        logic              rvalid;
        logic [word_w-1:0] rdata;
        logic [1:0]        resp;
        logic              last;
    } bus_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [word_w-1:0] inst;
        logic              fault;
    } fetch_packet_t;

endpackage

// ==== src/fetch_unit.sv ====
module fetch_unit #(
    parameter int          BLOCK_WORDS = 4,
    parameter logic [31:0] RESET_PC    = 32'h0
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       fetch_enable,
    input  logic                                       redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0]               redirect_pc,
    output logic                                       redirect_ready,
    output logic                                       packet_valid,
    output fetch_pkg::fetch_packet_t                   packet,
    input  logic                                       packet_ready,
    output logic                                       lookup_req,
    output logic [fetch_pkg::addr_w-1:0]               lookup_addr,
    input  logic                                       lookup_hit,
    input  logic [fetch_pkg::word_w-1:0]               lookup_data,
    output logic                                       fill_valid,
    output logic [fetch_pkg::addr_w-1:0]               fill_addr,
    output logic [BLOCK_WORDS*fetch_pkg::word_w-1:0]   fill_block,
    output fetch_pkg::bus_req_t                        bus_req,
    input  fetch_pkg::bus_rsp_t                        bus_rsp
);
    import fetch_pkg::*;

    localparam int off_w = $clog2(BLOCK_WORDS);

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_check   = 2'd1;
    localparam logic [1:0] st_refill  = 2'd2;
    localparam logic [1:0] st_present = 2'd3;

    logic [1:0]                    state;
    logic [addr_w-1:0]             pc;
    logic [addr_w-1:0]             blk_addr;
    logic                          req_valid;
    logic [off_w-1:0]              beat_cnt;
    logic                          fault_q;
    logic                          beat_fault;
    logic                          refill_done;
    logic                          take_redirect;
    logic [off_w-1:0]              pc_off;
    logic [BLOCK_WORDS*word_w-1:0] block_q;
    logic [BLOCK_WORDS*word_w-1:0] block_next;

    assign pc_off         = pc[off_w+1:2];
    assign redirect_ready = (state == st_idle) && fetch_enable;
    assign take_redirect  = redirect_valid && redirect_ready;
    assign lookup_req     = (state == st_idle) && fetch_enable && !take_redirect;
    assign lookup_addr    = pc;
    assign packet_valid   = (state == st_present);
    assign fill_addr      = blk_addr;
    assign fill_block     = block_q;

    assign beat_fault  = (bus_rsp.resp != resp_okay);
    assign refill_done = (state == st_refill) && bus_rsp.rvalid && bus_rsp.last;

    // block register with the current beat merged in
    always_comb begin
        block_next = block_q;
        if (bus_rsp.rvalid) begin
            block_next[beat_cnt*word_w +: word_w] = bus_rsp.rdata;
        end
    end

    always_comb begin
        bus_req       = '0;
        bus_req.valid = req_valid;
        bus_req.addr  = blk_addr;
        bus_req.len   = 8'(BLOCK_WORDS - 1);  // whole block per refill
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            pc         <= RESET_PC;
            req_valid  <= 1'b0;
            beat_cnt   <= '0;
            fault_q    <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (take_redirect) begin
                        pc <= redirect_pc;  // lookup follows next cycle
                    end else if (lookup_req) begin
                        state <= st_check;
                    end
                end
                st_check: begin
                    if (lookup_hit) begin
                        state <= st_present;
                    end else begin
                        req_valid <= 1'b1;
                        beat_cnt  <= '0;
                        fault_q   <= 1'b0;
                        state     <= st_refill;
                    end
                end
                st_refill: begin
                    if (req_valid && bus_rsp.req_ready) begin
                        req_valid <= 1'b0;
                    end
                    if (bus_rsp.rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        fault_q  <= fault_q | beat_fault;
                        if (bus_rsp.last) begin
                            fill_valid <= !(fault_q || beat_fault);  // faulted block stays out
                            state      <= st_present;
                        end
                    end
                end
                default: begin
                    if (packet_ready) begin
                        pc    <= pc + addr_w'(4);
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req) begin
            blk_addr <= {pc[addr_w-1:off_w+2], {(off_w + 2){1'b0}}};
        end
        if ((state == st_refill) && bus_rsp.rvalid) begin
            block_q <= block_next;
        end
        if ((state == st_check) && lookup_hit) begin
            packet.pc    <= pc;
            packet.inst  <= lookup_data;
            packet.fault <= 1'b0;
        end else if (refill_done) begin
            packet.pc    <= pc;
            packet.fault <= fault_q | beat_fault;
            packet.inst  <= (fault_q | beat_fault) ? '0 : block_next[pc_off*word_w +: word_w];
        end
    end

endmodule

// ==== src/icache.sv ====
module icache #(
    parameter int BLOCK_WORDS = 4,
    parameter int LINES       = 8
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     lookup_req,
    input  logic [fetch_pkg::addr_w-1:0]             lookup_addr,
    output logic                                     lookup_hit,
    output logic [fetch_pkg::word_w-1:0]             lookup_data,
    input  logic                                     fill_valid,
    input  logic [fetch_pkg::addr_w-1:0]             fill_addr,
    input  logic [BLOCK_WORDS*fetch_pkg::word_w-1:0] fill_block
);
    import fetch_pkg::*;

    localparam int off_w = $clog2(BLOCK_WORDS);
    localparam int idx_w = $clog2(LINES);
    localparam int tag_w = addr_w - idx_w - off_w - 2;

    logic [LINES-1:0]              valid;
    logic [tag_w-1:0]              tags   [LINES];
    logic [BLOCK_WORDS*word_w-1:0] blocks [LINES];

    logic [idx_w-1:0]              rd_idx;
    logic [tag_w-1:0]              rd_tag;
    logic [off_w-1:0]              rd_off;
    logic [BLOCK_WORDS*word_w-1:0] rd_block;
    logic [idx_w-1:0]              wr_idx;
    logic [tag_w-1:0]              wr_tag;

    // addr = tag | index | word offset | byte offset
    assign rd_idx   = lookup_addr[off_w+2 +: idx_w];
    assign rd_tag   = lookup_addr[addr_w-1 -: tag_w];
    assign rd_off   = lookup_addr[2 +: off_w];
    assign rd_block = blocks[rd_idx];

    assign wr_idx = fill_addr[off_w+2 +: idx_w];
    assign wr_tag = fill_addr[addr_w-1 -: tag_w];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid      <= '0;
            lookup_hit <= 1'b0;
        end else begin
            if (fill_valid) begin
                valid[wr_idx] <= 1'b1;
            end
            if (lookup_req) begin
                lookup_hit <= valid[rd_idx] && (tags[rd_idx] == rd_tag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tags[wr_idx]   <= wr_tag;
            blocks[wr_idx] <= fill_block;  // whole block at once
        end
        if (lookup_req) begin
            lookup_data <= rd_block[rd_off*word_w +: word_w];
        end
    end

endmodule

// ==== src/bus_arbiter.sv ====
module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::bus_req_t m0_req,
    input  fetch_pkg::bus_req_t m1_req,
    output fetch_pkg::bus_rsp_t m0_rsp,
    output fetch_pkg::bus_rsp_t m1_rsp,
    output fetch_pkg::bus_req_t s_req,
    input  fetch_pkg::bus_rsp_t s_rsp
);
    logic       locked;  // transaction in flight
    logic       owner;   // high when m1 was served last
    logic [1:0] gnt;

    always_comb begin
        if (locked) begin
            gnt = owner ? 2'b10 : 2'b01;
        end else if (m0_req.valid && m1_req.valid) begin
            gnt = owner ? 2'b01 : 2'b10;  // round robin
        end else begin
            gnt = {m1_req.valid, m0_req.valid};
        end
    end

    always_comb begin
        s_req = '0;
        if (gnt[0]) begin
            s_req = m0_req;
        end else if (gnt[1]) begin
            s_req = m1_req;
        end
    end

    // the loser sees no handshake activity
    always_comb begin
        m0_rsp           = s_rsp;
        m0_rsp.req_ready = s_rsp.req_ready && gnt[0];
        m0_rsp.rvalid    = s_rsp.rvalid && gnt[0];
        m1_rsp           = s_rsp;
        m1_rsp.req_ready = s_rsp.req_ready && gnt[1];
        m1_rsp.rvalid    = s_rsp.rvalid && gnt[1];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= 1'b1;  // m0 wins the first tie
        end else if (s_req.valid && s_rsp.req_ready) begin
            locked <= 1'b1;
            owner  <= gnt[1];
        end else if (locked && s_rsp.rvalid && s_rsp.last) begin
            locked <= 1'b0;
        end
    end

endmodule

// ==== src/data_port.sv ====
module data_port (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dp_req,
    input  logic                         dp_write,
    input  logic [fetch_pkg::addr_w-1:0] dp_addr,
    input  logic [fetch_pkg::word_w-1:0] dp_wdata,
    output logic                         dp_ack,
    output logic [fetch_pkg::word_w-1:0] dp_rdata,
    output logic                         dp_err,
    output fetch_pkg::bus_req_t          bus_req,
    input  fetch_pkg::bus_rsp_t          bus_rsp
);
    import fetch_pkg::*;

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_addr    = 3'd1;
    localparam logic [2:0] st_wait    = 3'd2;
    localparam logic [2:0] st_ack     = 3'd3;
    localparam logic [2:0] st_release = 3'd4;

    logic [2:0]        state;
    logic              wr_q;
    logic [addr_w-1:0] addr_q;
    logic [word_w-1:0] wdata_q;

    assign dp_ack = (state == st_ack);

    always_comb begin
        bus_req       = '0;
        bus_req.valid = (state == st_addr);
        bus_req.write = wr_q;
        bus_req.addr  = addr_q;
        bus_req.len   = 8'd0;  // single beat
        bus_req.wdata = wdata_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (dp_req) state <= st_addr;
                st_addr:    if (bus_rsp.req_ready) state <= st_wait;
                st_wait:    if (bus_rsp.rvalid) state <= st_ack;
                st_ack:     if (!dp_req) state <= st_release;
                default:    state <= st_idle;  // ack already low here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && dp_req) begin
            wr_q    <= dp_write;
            addr_q  <= dp_addr;
            wdata_q <= dp_wdata;
        end
        if ((state == st_wait) && bus_rsp.rvalid) begin
            dp_rdata <= bus_rsp.rdata;
            dp_err   <= (bus_rsp.resp != resp_okay);
        end
    end

endmodule

// ==== src/word_memory.sv ====
module word_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::bus_req_t req,
    output fetch_pkg::bus_rsp_t rsp
);
    import fetch_pkg::*;

    localparam int                idx_w = $clog2(MEM_WORDS);
    localparam logic [addr_w-1:0] limit = addr_w'(MEM_WORDS * 4);

    logic [word_w-1:0] mem [MEM_WORDS];

    logic              busy;
    logic [7:0]        beats_left;
    logic              accept;
    logic [addr_w-1:0] beat_addr;
    logic [addr_w-1:0] next_addr;
    logic [word_w-1:0] rdata_q;

    assign accept    = req.valid && !busy;
    assign next_addr = accept ? req.addr : beat_addr + addr_w'(4);

    always_comb begin
        rsp           = '0;
        rsp.req_ready = !busy;  // one transaction at a time
        rsp.rvalid    = busy;
        rsp.rdata     = rdata_q;
        rsp.resp      = (beat_addr < limit) ? resp_okay : resp_slverr;
        rsp.last      = busy && (beats_left == 8'd0);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            beats_left <= 8'd0;
        end else if (accept) begin
            busy       <= 1'b1;
            beats_left <= req.write ? 8'd0 : req.len;  // write answers with one beat
        end else if (busy) begin
            if (beats_left == 8'd0) begin
                busy <= 1'b0;
            end else begin
                beats_left <= beats_left - 8'd1;
            end
        end
    end

    // beat address and read data run one word ahead of the response
    always_ff @(posedge clk) begin
        if (accept || busy) begin
            beat_addr <= next_addr;
            rdata_q   <= mem[next_addr[idx_w+1:2]];
        end
        if (accept && req.write && (req.addr < limit)) begin
            mem[req.addr[idx_w+1:2]] <= req.wdata;
        end
    end

endmodule

// ==== src/fetch_top.sv ====
module fetch_top #(
    parameter int          BLOCK_WORDS = 4,
    parameter int          LINES       = 8,
    parameter int          MEM_WORDS   = 256,
    parameter logic [31:0] RESET_PC    = 32'h0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_enable,
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
    output logic                         redirect_ready,
    output logic                         packet_valid,
    output fetch_pkg::fetch_packet_t     packet,
    input  logic                         packet_ready,
    input  logic                         dp_req,
    input  logic                         dp_write,
    input  logic [fetch_pkg::addr_w-1:0] dp_addr,
    input  logic [fetch_pkg::word_w-1:0] dp_wdata,
    output logic                         dp_ack,
    output logic [fetch_pkg::word_w-1:0] dp_rdata,
    output logic                         dp_err
);
    import fetch_pkg::*;

    logic                          lookup_req;
    logic [addr_w-1:0]             lookup_addr;
    logic                          lookup_hit;
    logic [word_w-1:0]             lookup_data;
    logic                          fill_valid;
    logic [addr_w-1:0]             fill_addr;
    logic [BLOCK_WORDS*word_w-1:0] fill_block;

    bus_req_t fu_bus_req;
    bus_rsp_t fu_bus_rsp;
    bus_req_t dp_bus_req;
    bus_rsp_t dp_bus_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;

    fetch_unit #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .RESET_PC    (RESET_PC)
    ) fetch_unit_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_enable   (fetch_enable),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_ready (redirect_ready),
        .packet_valid   (packet_valid),
        .packet         (packet),
        .packet_ready   (packet_ready),
        .lookup_req     (lookup_req),
        .lookup_addr    (lookup_addr),
        .lookup_hit     (lookup_hit),
        .lookup_data    (lookup_data),
        .fill_valid     (fill_valid),
        .fill_addr      (fill_addr),
        .fill_block     (fill_block),
        .bus_req        (fu_bus_req),
        .bus_rsp        (fu_bus_rsp)
    );

    icache #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .LINES       (LINES)
    ) icache_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .lookup_hit  (lookup_hit),
        .lookup_data (lookup_data),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_block  (fill_block)
    );

    data_port data_port_i (
        .clk      (clk),
        .rst      (rst),
        .dp_req   (dp_req),
        .dp_write (dp_write),
        .dp_addr  (dp_addr),
        .dp_wdata (dp_wdata),
        .dp_ack   (dp_ack),
        .dp_rdata (dp_rdata),
        .dp_err   (dp_err),
        .bus_req  (dp_bus_req),
        .bus_rsp  (dp_bus_rsp)
    );

    // refill is master 0, data port master 1
    bus_arbiter bus_arbiter_i (
        .clk    (clk),
        .rst    (rst),
        .m0_req (fu_bus_req),
        .m1_req (dp_bus_req),
        .m0_rsp (fu_bus_rsp),
        .m1_rsp (dp_bus_rsp),
        .s_req  (mem_req),
        .s_rsp  (mem_rsp)
    );

    word_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) word_memory_i (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;  // 8 ns period
        end
    end

endmodule

// ==== test/fetch_assertions.sv ====
module fetch_assertions (
    input logic                     clk,
    input logic                     rst,
    input logic                     packet_valid,
    input fetch_pkg::fetch_packet_t packet,
    input logic                     packet_ready,
    input logic                     dp_req,
    input logic                     dp_ack,
    input logic                     redirect_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // failed assertions so far

    // a stalled packet stays put until it is taken
    packet_held: assert property (@(posedge clk) disable iff (rst)
        packet_valid && !packet_ready |=> packet_valid && $stable(packet))
        else begin
            fail_count++;
            $error("packet changed or dropped while stalled");
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(dp_ack) |-> dp_req)
        else begin
            fail_count++;
            $error("dp_ack rose without dp_req");
        end

    // redirects only between packets
    redirect_idle: assert property (@(posedge clk) disable iff (rst)
        !(redirect_ready && packet_valid))
        else begin
            fail_count++;
            $error("redirect_ready high while a packet is pending");
        end

endmodule

// ==== test/fetch_tb.sv ====
module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;

    localparam int          BLOCK_WORDS = 4;
    localparam int          LINES       = 8;
    localparam int          MEM_WORDS   = 256;
    localparam logic [31:0] RESET_PC    = 32'h0;
    localparam logic [31:0] mem_limit   = 32'(MEM_WORDS * 4);

    localparam logic [1:0] k_write    = 2'd0;
    localparam logic [1:0] k_read     = 2'd1;
    localparam logic [1:0] k_redirect = 2'd2;
    localparam logic [1:0] k_fetch    = 2'd3;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;  // word address, redirect target or expected pc
        logic [31:0] data;
        logic        err;   // expected dp_err or packet fault
    } step_t;

    logic          clk;
    logic          rst;
    logic          fetch_enable;
    logic          redirect_valid;
    logic [31:0]   redirect_pc;
    logic          redirect_ready;
    logic          packet_valid;
    fetch_packet_t packet;
    logic          packet_ready;
    logic          dp_req;
    logic          dp_write;
    logic [31:0]   dp_addr;
    logic [31:0]   dp_wdata;
    logic          dp_ack;
    logic [31:0]   dp_rdata;
    logic          dp_err;

    step_t       steps[$];
    logic [31:0] ref_mem [MEM_WORDS];
    int          cycles = 0;
    int          cycle_limit;

    tb_clock tb_clock_i (.clk(clk));

    fetch_top #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .LINES       (LINES),
        .MEM_WORDS   (MEM_WORDS),
        .RESET_PC    (RESET_PC)
    ) fetch_top_i (.*);

    bind fetch_top fetch_assertions fetch_assertions_i (
        .clk            (clk),
        .rst            (rst),
        .packet_valid   (packet_valid),
        .packet         (packet),
        .packet_ready   (packet_ready),
        .dp_req         (dp_req),
        .dp_ack         (dp_ack),
        .redirect_ready (redirect_ready)
    );

    function automatic logic [31:0] pattern(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h1357_2468;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic add_step(input logic [1:0] kind, input logic [31:0] addr, input logic err);
        steps.push_back('{kind, addr, pattern(addr), err});
    endtask

    // four-phase access that returns what was on the bus at ack time
    task automatic dp_access(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        logic ack;
        dp_write = write;
        dp_addr  = addr;
        dp_wdata = wdata;
        dp_req   = 1'b1;
        do begin
            @(negedge clk);
            ack   = dp_ack;
            rdata = dp_rdata;
            err   = dp_err;
            @(posedge clk);
            #1;
        end while (!ack);
        dp_req = 1'b0;
        do begin
            @(negedge clk);
            ack = dp_ack;
            @(posedge clk);
            #1;
        end while (ack);
    endtask

    task automatic redirect_to(input logic [31:0] target);
        logic taken;
        fetch_enable   = 1'b1;
        redirect_pc    = target;
        redirect_valid = 1'b1;
        do begin
            @(negedge clk);
            taken = redirect_ready;
            @(posedge clk);
            #1;
        end while (!taken);
        redirect_valid = 1'b0;
    endtask

    task automatic fetch_expect(input step_t s, input int idx);
        fetch_packet_t pkt;
        logic          got;
        logic [31:0]   inst;
        fetch_enable = 1'b1;
        do begin
            packet_ready = ($urandom % 4) != 0;  // random stalls
            @(negedge clk);
            got = packet_valid && packet_ready;
            pkt = packet;
            @(posedge clk);
            #1;
        end while (!got);
        packet_ready = 1'b0;
        inst = s.err ? 32'h0 : ref_mem[s.addr >> 2];
        check(pkt.pc, s.addr, $sformatf("step %0d packet pc", idx));
        check(pkt.inst, inst, $sformatf("step %0d packet inst", idx));
        check(32'(pkt.fault), 32'(s.err), $sformatf("step %0d packet fault", idx));
    endtask

    task automatic apply_step(input step_t s, input int idx);
        logic [31:0] rdata;
        logic        err;
        case (s.kind)
            k_write: begin
                dp_access(1'b1, s.addr, s.data, rdata, err);
                check(32'(err), 32'(s.err), $sformatf("step %0d write error flag", idx));
                if (s.addr < mem_limit) begin
                    ref_mem[s.addr >> 2] = s.data;
                end
            end
            k_read: begin
                dp_access(1'b0, s.addr, 32'h0, rdata, err);
                check(32'(err), 32'(s.err), $sformatf("step %0d read error flag", idx));
                if (!s.err) begin
                    check(rdata, s.data, $sformatf("step %0d read data", idx));
                end
            end
            k_redirect: redirect_to(s.addr);
            default:    fetch_expect(s, idx);
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(fetch_top_i.fetch_assertions_i.fail_count) begin
        if (fetch_top_i.fetch_assertions_i.fail_count != 0) begin
            $display("a handshake assertion failed, see the error above");
            $display("TEST FAILED");
            $fatal(1, "assertion");
        end
    end

    initial begin
        void'($urandom(32'h62a3_9bdc));
        rst            = 1'b1;
        fetch_enable   = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        packet_ready   = 1'b0;
        dp_req         = 1'b0;
        dp_write       = 1'b0;
        dp_addr        = '0;
        dp_wdata       = '0;

        for (int a = 0; a < 64; a += 4) begin
            add_step(k_write, 32'(a), 1'b0);  // program in four blocks
        end
        add_step(k_read, 32'h00, 1'b0);
        add_step(k_read, 32'h1c, 1'b0);
        add_step(k_write, mem_limit, 1'b1);
        add_step(k_read, mem_limit + 32'h4, 1'b1);
        for (int a = 0; a < 16; a += 4) begin
            add_step(k_fetch, 32'(a), 1'b0);
        end
        // data traffic while block 0x10 refills
        add_step(k_write, 32'h200, 1'b0);
        add_step(k_write, 32'h204, 1'b0);
        add_step(k_read, 32'h200, 1'b0);
        for (int a = 16; a < 32; a += 4) begin
            add_step(k_fetch, 32'(a), 1'b0);
        end
        add_step(k_write, 32'h208, 1'b0);
        add_step(k_read, 32'h204, 1'b0);
        add_step(k_read, 32'h208, 1'b0);
        add_step(k_fetch, 32'h20, 1'b0);
        add_step(k_redirect, 32'h04, 1'b0);  // back into cached blocks
        add_step(k_fetch, 32'h04, 1'b0);
        add_step(k_fetch, 32'h08, 1'b0);
        add_step(k_redirect, 32'h18, 1'b0);
        for (int a = 24; a < 40; a += 4) begin
            add_step(k_fetch, 32'(a), 1'b0);
        end
        add_step(k_redirect, mem_limit, 1'b0);
        add_step(k_fetch, mem_limit, 1'b1);
        add_step(k_redirect, 32'h30, 1'b0);
        add_step(k_fetch, 32'h30, 1'b0);
        add_step(k_fetch, 32'h34, 1'b0);
        add_step(k_redirect, 32'h00, 1'b0);
        add_step(k_fetch, 32'h00, 1'b0);
        add_step(k_read, 32'h30, 1'b0);
        cycle_limit = steps.size() * 200 + 16;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i], i);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== project.f ====
src/fetch_pkg.sv
src/fetch_unit.sv
src/icache.sv
src/bus_arbiter.sv
src/data_port.sv
src/word_memory.sv
src/fetch_top.sv
test/tb_clock.sv
test/fetch_assertions.sv
test/fetch_tb.sv
